//--- verilog/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// datapath and address widths
`define XLEN                32
`define CSR_ADDR_W          12

// machine-mode csr addresses
`define CSR_MSTATUS_ADDR    `CSR_ADDR_W'h300
`define CSR_MIE_ADDR        `CSR_ADDR_W'h304
`define CSR_MTVEC_ADDR      `CSR_ADDR_W'h305
`define CSR_MSCRATCH_ADDR   `CSR_ADDR_W'h340
`define CSR_MEPC_ADDR       `CSR_ADDR_W'h341
`define CSR_MCAUSE_ADDR     `CSR_ADDR_W'h342
`define CSR_MTVAL_ADDR      `CSR_ADDR_W'h343
`define CSR_MCYCLE_ADDR     `CSR_ADDR_W'hb00
`define CSR_MINSTRET_ADDR   `CSR_ADDR_W'hb02
`define CSR_MVENDORID_ADDR  `CSR_ADDR_W'hf11
`define CSR_MARCHID_ADDR    `CSR_ADDR_W'hf12

// instruction encodings
`define OPC_SYSTEM          7'b111_0011
`define FUNCT3_ECALL_MRET   3'b000
`define INST_ECALL          32'h0000_0073
`define INST_MRET           32'h3020_0073

// mstatus.mpp, both bits
`define MSTATUS_MPP_MASK    `XLEN'h0000_1800

// environment call from m-mode
`define CAUSE_ECALL_M       `XLEN'd11

// identification registers
`define MVENDORID_VAL       `XLEN'h0000_0c5a
`define MARCHID_VAL         `XLEN'h0000_0017

`endif

//--- verilog/csr_pkg.sv
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

    typedef logic [`XLEN-1:0]       data_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [31:0]            inst_t;

    // encoding follows funct3[1:0] of the csr instructions
    typedef enum logic [1:0] {
        CSR_NONE = 2'b00,
        CSR_RW   = 2'b01,
        CSR_RS   = 2'b10,
        CSR_RC   = 2'b11
    } csr_op_t;

    typedef struct packed {
        logic      rd_en;
        logic      wr_en;
        csr_op_t   op;
        csr_addr_t addr;
        data_t     wdata;
        logic      ecall;
        logic      mret;
    } csr_req_t;

    typedef struct packed {
        logic  hit;
        data_t data;
    } csr_rd_t;

    // new register value for a read-modify-write
    function automatic data_t csr_apply(csr_op_t op, data_t old_val, data_t src);
        data_t res;
        case (op)
            CSR_RW:  res = src;
            CSR_RS:  res = old_val | src;
            CSR_RC:  res = old_val & ~src;
            default: res = old_val;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

//--- verilog/sys_decode.sv
`default_nettype none

`include "csr_consts.svh"

module sys_decode (
    input  wire csr_pkg::inst_t   i_inst,
    input  wire csr_pkg::data_t   i_rs1_data,
    output csr_pkg::csr_req_t     o_req
);

    import csr_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] src_field;
    logic       is_system;
    logic       is_access;
    logic       is_priv;
    csr_op_t    op;

    assign opcode    = i_inst[6:0];
    assign funct3    = i_inst[14:12];
    assign src_field = i_inst[19:15];

    assign is_system = (opcode == `OPC_SYSTEM);
    // funct3 of 000 and 100 carry no csr access
    assign is_access = is_system && (funct3[1:0] != 2'b00);
    assign is_priv   = is_system && (funct3 == `FUNCT3_ECALL_MRET);
    assign op        = is_access ? csr_op_t'(funct3[1:0]) : CSR_NONE;

    always_comb begin
        o_req.rd_en = is_access;
        // set and clear with a zero field only read
        o_req.wr_en = is_access && ((op == CSR_RW) || (src_field != 5'd0));
        o_req.op    = op;
        o_req.addr  = i_inst[31:20];
        if (funct3[2]) begin
            o_req.wdata = {{(`XLEN-5){1'b0}}, src_field};
        end else begin
            o_req.wdata = i_rs1_data;
        end
        o_req.ecall = is_priv && (i_inst == `INST_ECALL);
        o_req.mret  = is_priv && (i_inst == `INST_MRET);
    end

    // trap entry and return must never be decoded together
    always_comb begin
        assert (!(o_req.ecall && o_req.mret))
            else $error("sys_decode: ecall and mret decoded in the same cycle");
    end

endmodule

`default_nettype wire

//--- verilog/trap_csrs.sv
`default_nettype none

`include "csr_consts.svh"

module trap_csrs (
    input  wire                    clk,
    input  wire                    reset,
    input  wire csr_pkg::csr_req_t i_req,
    input  wire csr_pkg::data_t    i_pc,
    output csr_pkg::csr_rd_t       o_rd,
    output csr_pkg::data_t         o_mstatus,
    output csr_pkg::data_t         o_mtvec,
    output csr_pkg::data_t         o_mepc
);

    import csr_pkg::*;

    data_t mstatus;
    data_t mie;
    data_t mtvec;
    data_t mscratch;
    data_t mepc;
    data_t mcause;
    data_t mtval;

    logic  csr_wr;
    logic  wr_mstatus;
    logic  wr_mie;
    logic  wr_mtvec;
    logic  wr_mscratch;
    logic  wr_mepc;
    logic  wr_mcause;
    logic  wr_mtval;

    // trap events win over any csr write
    assign csr_wr      = i_req.wr_en && !i_req.ecall && !i_req.mret;
    assign wr_mstatus  = csr_wr && (i_req.addr == `CSR_MSTATUS_ADDR);
    assign wr_mie      = csr_wr && (i_req.addr == `CSR_MIE_ADDR);
    assign wr_mtvec    = csr_wr && (i_req.addr == `CSR_MTVEC_ADDR);
    assign wr_mscratch = csr_wr && (i_req.addr == `CSR_MSCRATCH_ADDR);
    assign wr_mepc     = csr_wr && (i_req.addr == `CSR_MEPC_ADDR);
    assign wr_mcause   = csr_wr && (i_req.addr == `CSR_MCAUSE_ADDR);
    assign wr_mtval    = csr_wr && (i_req.addr == `CSR_MTVAL_ADDR);

    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else begin
            if (i_req.ecall) begin
                mstatus <= mstatus | `MSTATUS_MPP_MASK;
            end else if (i_req.mret) begin
                mstatus <= mstatus & ~`MSTATUS_MPP_MASK;
            end else if (wr_mstatus) begin
                mstatus <= csr_apply(i_req.op, mstatus, i_req.wdata);
            end

            if (i_req.ecall) begin
                mepc <= i_pc;
            end else if (wr_mepc) begin
                mepc <= csr_apply(i_req.op, mepc, i_req.wdata);
            end

            if (i_req.ecall) begin
                mcause <= `CAUSE_ECALL_M;
            end else if (wr_mcause) begin
                mcause <= csr_apply(i_req.op, mcause, i_req.wdata);
            end

            // plain storage, no trap side effects
            if (wr_mie) begin
                mie <= csr_apply(i_req.op, mie, i_req.wdata);
            end
            if (wr_mtvec) begin
                mtvec <= csr_apply(i_req.op, mtvec, i_req.wdata);
            end
            if (wr_mscratch) begin
                mscratch <= csr_apply(i_req.op, mscratch, i_req.wdata);
            end
            if (wr_mtval) begin
                mtval <= csr_apply(i_req.op, mtval, i_req.wdata);
            end
        end
    end

    // read port, old value of the addressed register
    always_comb begin
        o_rd.hit = 1'b1;
        case (i_req.addr)
            `CSR_MSTATUS_ADDR:  o_rd.data = mstatus;
            `CSR_MIE_ADDR:      o_rd.data = mie;
            `CSR_MTVEC_ADDR:    o_rd.data = mtvec;
            `CSR_MSCRATCH_ADDR: o_rd.data = mscratch;
            `CSR_MEPC_ADDR:     o_rd.data = mepc;
            `CSR_MCAUSE_ADDR:   o_rd.data = mcause;
            `CSR_MTVAL_ADDR:    o_rd.data = mtval;
            default: begin
                o_rd.hit  = 1'b0;
                o_rd.data = '0;
            end
        endcase
    end

    assign o_mstatus = mstatus;
    assign o_mtvec   = mtvec;
    assign o_mepc    = mepc;

    // an ecall cycle must not leak into the storage registers
    property ecall_keeps_storage;
        @(posedge clk) disable iff (reset)
        i_req.ecall |=> (mie == $past(mie)) && (mtvec == $past(mtvec)) &&
                        (mscratch == $past(mscratch)) && (mtval == $past(mtval));
    endproperty

    assert property (ecall_keeps_storage)
        else $error("trap_csrs: csr write applied during ecall");

endmodule

`default_nettype wire

//--- verilog/perf_counters.sv
`default_nettype none

`include "csr_consts.svh"

module perf_counters (
    input  wire                    clk,
    input  wire                    reset,
    input  wire csr_pkg::csr_req_t i_req,
    input  wire                    i_retire,
    output csr_pkg::csr_rd_t       o_rd
);

    import csr_pkg::*;

    data_t mcycle;
    data_t minstret;
    logic  wr_mcycle;
    logic  wr_minstret;

    assign wr_mcycle   = i_req.wr_en && (i_req.addr == `CSR_MCYCLE_ADDR);
    assign wr_minstret = i_req.wr_en && (i_req.addr == `CSR_MINSTRET_ADDR);

    // a csr write overrides the increment
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            if (wr_mcycle) begin
                mcycle <= csr_apply(i_req.op, mcycle, i_req.wdata);
            end else begin
                mcycle <= mcycle + data_t'(1);
            end

            if (wr_minstret) begin
                minstret <= csr_apply(i_req.op, minstret, i_req.wdata);
            end else if (i_retire) begin
                minstret <= minstret + data_t'(1);
            end
        end
    end

    always_comb begin
        o_rd.hit = 1'b1;
        case (i_req.addr)
            `CSR_MCYCLE_ADDR:   o_rd.data = mcycle;
            `CSR_MINSTRET_ADDR: o_rd.data = minstret;
            default: begin
                o_rd.hit  = 1'b0;
                o_rd.data = '0;
            end
        endcase
    end

    // counter writes are not gated by trap events here
    assert property (@(posedge clk) disable iff (reset)
        i_req.wr_en |-> !(i_req.ecall || i_req.mret))
        else $error("perf_counters: csr write requested with ecall or mret");

endmodule

`default_nettype wire

//--- verilog/csr_result.sv
`default_nettype none

`include "csr_consts.svh"

module csr_result (
    input  wire csr_pkg::csr_req_t i_req,
    input  wire csr_pkg::csr_rd_t  i_trap_rd,
    input  wire csr_pkg::csr_rd_t  i_cnt_rd,
    input  wire csr_pkg::data_t    i_mtvec,
    input  wire csr_pkg::data_t    i_mepc,
    output csr_pkg::data_t         o_rd_data,
    output logic                   o_illegal,
    output logic                   o_redirect,
    output csr_pkg::data_t         o_redirect_pc
);

    import csr_pkg::*;

    logic  ro_addr;
    logic  const_hit;
    data_t const_data;
    logic  any_hit;
    logic  bad_access;

    // top address bits 11 mark the read-only space
    assign ro_addr = (i_req.addr[`CSR_ADDR_W-1 -: 2] == 2'b11);

    always_comb begin
        const_hit = 1'b1;
        case (i_req.addr)
            `CSR_MVENDORID_ADDR: const_data = `MVENDORID_VAL;
            `CSR_MARCHID_ADDR:   const_data = `MARCHID_VAL;
            default: begin
                const_hit  = 1'b0;
                const_data = '0;
            end
        endcase
    end

    assign any_hit    = i_trap_rd.hit || i_cnt_rd.hit || const_hit;
    assign bad_access = !any_hit || (ro_addr && i_req.wr_en);
    assign o_illegal  = i_req.rd_en && bad_access;

    always_comb begin
        o_rd_data = '0;
        if (i_req.rd_en && !bad_access) begin
            if (i_trap_rd.hit) begin
                o_rd_data = i_trap_rd.data;
            end else if (i_cnt_rd.hit) begin
                o_rd_data = i_cnt_rd.data;
            end else begin
                o_rd_data = const_data;
            end
        end
    end

    // targets are the pre-edge register values
    assign o_redirect    = i_req.ecall || i_req.mret;
    assign o_redirect_pc = i_req.ecall ? i_mtvec : (i_req.mret ? i_mepc : '0);

    // the two register blocks own disjoint address sets
    always_comb begin
        assert (!(i_trap_rd.hit && i_cnt_rd.hit))
            else $error("csr_result: trap and counter blocks both claim 0x%h", i_req.addr);
    end

endmodule

`default_nettype wire

//--- verilog/csr_unit.sv
`default_nettype none

module csr_unit (
    input  wire                  clk,
    input  wire                  reset,
    input  wire csr_pkg::inst_t  i_inst,
    input  wire csr_pkg::data_t  i_pc,
    input  wire csr_pkg::data_t  i_rs1_data,
    input  wire                  i_retire,
    output csr_pkg::data_t       o_rd_data,
    output logic                 o_illegal,
    output logic                 o_redirect,
    output csr_pkg::data_t       o_redirect_pc,
    output csr_pkg::data_t       o_mstatus
);

    import csr_pkg::*;

    csr_req_t req;
    csr_rd_t  trap_rd;
    csr_rd_t  cnt_rd;
    data_t    mtvec;
    data_t    mepc;

    sys_decode u_decode (
        .i_inst     (i_inst),
        .i_rs1_data (i_rs1_data),
        .o_req      (req)
    );

    trap_csrs u_trap (
        .clk       (clk),
        .reset     (reset),
        .i_req     (req),
        .i_pc      (i_pc),
        .o_rd      (trap_rd),
        .o_mstatus (o_mstatus),
        .o_mtvec   (mtvec),
        .o_mepc    (mepc)
    );

    perf_counters u_counters (
        .clk      (clk),
        .reset    (reset),
        .i_req    (req),
        .i_retire (i_retire),
        .o_rd     (cnt_rd)
    );

    csr_result u_result (
        .i_req         (req),
        .i_trap_rd     (trap_rd),
        .i_cnt_rd      (cnt_rd),
        .i_mtvec       (mtvec),
        .i_mepc        (mepc),
        .o_rd_data     (o_rd_data),
        .o_illegal     (o_illegal),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc)
    );

endmodule

`default_nettype wire

//--- verification/csr_unit_tb.sv
`default_nettype none

`include "csr_consts.svh"

module csr_unit_tb;

    import csr_pkg::*;

    localparam int    CLK_PERIOD  = 20;
    localparam int    N_RMW       = 200;
    localparam int    N_TRAP      = 8;
    localparam int    N_CNT       = 10;
    localparam int    MAX_GAP     = 16;
    localparam int    N_ILL       = 40;
    localparam int    N_MIX       = 2000;
    // worst case cycles over all tests, reset included
    localparam int    TEST_CYCLES = 3 + 11 + 2 * N_RMW + 8 * N_TRAP
                                  + N_CNT * (2 * MAX_GAP + 8) + 3 * N_ILL + N_MIX;
    localparam int    MARGIN      = 100;
    localparam inst_t NOP_INST    = 32'h0000_0013;
    localparam inst_t ECALL_INST  = 32'h0000_0073;
    localparam inst_t MRET_INST   = 32'h3020_0073;
    localparam data_t MPP_BITS    = 32'h0000_1800;

    localparam csr_addr_t RW_ADDRS [9] = '{
        `CSR_MSTATUS_ADDR, `CSR_MIE_ADDR, `CSR_MTVEC_ADDR, `CSR_MSCRATCH_ADDR,
        `CSR_MEPC_ADDR, `CSR_MCAUSE_ADDR, `CSR_MTVAL_ADDR, `CSR_MCYCLE_ADDR,
        `CSR_MINSTRET_ADDR
    };

    typedef struct packed {
        data_t rd_data;
        logic  illegal;
        logic  redirect;
        data_t redirect_pc;
    } expect_t;

    logic        clk;
    logic        reset;
    inst_t       i_inst;
    data_t       i_pc;
    data_t       i_rs1_data;
    logic        i_retire;
    data_t       o_rd_data;
    logic        o_illegal;
    logic        o_redirect;
    data_t       o_redirect_pc;
    data_t       o_mstatus;

    // reference copy of every csr, keyed by address
    data_t       csr_model [csr_addr_t];
    logic [31:0] rng_state;
    logic        checking;
    int          errors;
    int          checks;
    int          test_err_base;
    int          tests_passed;
    int          tests_failed;

    csr_unit i_dut (
        .clk           (clk),
        .reset         (reset),
        .i_inst        (i_inst),
        .i_pc          (i_pc),
        .i_rs1_data    (i_rs1_data),
        .i_retire      (i_retire),
        .o_rd_data     (o_rd_data),
        .o_illegal     (o_illegal),
        .o_redirect    (o_redirect),
        .o_redirect_pc (o_redirect_pc),
        .o_mstatus     (o_mstatus)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic inst_t csr_inst(input logic [2:0] f3, input csr_addr_t addr,
                                       input logic [4:0] field);
        return {addr, field, f3, 5'd5, 7'b111_0011};
    endfunction

    task automatic model_reset();
        foreach (RW_ADDRS[k]) begin
            csr_model[RW_ADDRS[k]] = '0;
        end
        csr_model[`CSR_MVENDORID_ADDR] = `MVENDORID_VAL;
        csr_model[`CSR_MARCHID_ADDR]   = `MARCHID_VAL;
    endtask

    // expected outputs for this cycle, then the state after the edge
    function automatic expect_t model_step(input inst_t inst, input data_t rs1,
                                           input data_t pc, input logic retire);
        expect_t    res;
        logic [2:0] f3;
        logic [4:0] field;
        csr_addr_t  addr;
        logic       access;
        logic       writes;
        logic       known;
        data_t      src;
        data_t      old;
        data_t      nv;

        f3     = inst[14:12];
        field  = inst[19:15];
        addr   = inst[31:20];
        access = (inst[6:0] == 7'b111_0011) && (f3[1:0] != 2'b00);
        writes = access && ((f3[1:0] == 2'b01) || (field != 5'd0));
        src    = f3[2] ? {27'd0, field} : rs1;
        known  = (csr_model.exists(addr) != 0);
        old    = '0;
        if (known) begin
            old = csr_model[addr];
        end
        case (f3[1:0])
            2'b01:   nv = src;
            2'b10:   nv = old | src;
            default: nv = old & ~src;
        endcase

        res.illegal     = access && (!known || ((addr[11:10] == 2'b11) && writes));
        res.rd_data     = (access && !res.illegal) ? old : '0;
        res.redirect    = (inst == ECALL_INST) || (inst == MRET_INST);
        res.redirect_pc = '0;
        if (inst == ECALL_INST) begin
            res.redirect_pc = csr_model[`CSR_MTVEC_ADDR];
        end else if (inst == MRET_INST) begin
            res.redirect_pc = csr_model[`CSR_MEPC_ADDR];
        end

        // counters tick, a csr write in the same cycle wins
        csr_model[`CSR_MCYCLE_ADDR] = csr_model[`CSR_MCYCLE_ADDR] + 1;
        if (retire) begin
            csr_model[`CSR_MINSTRET_ADDR] = csr_model[`CSR_MINSTRET_ADDR] + 1;
        end
        if (writes && !res.illegal) begin
            csr_model[addr] = nv;
        end
        if (inst == ECALL_INST) begin
            csr_model[`CSR_MEPC_ADDR]    = pc;
            csr_model[`CSR_MCAUSE_ADDR]  = 32'd11;
            csr_model[`CSR_MSTATUS_ADDR] = csr_model[`CSR_MSTATUS_ADDR] | MPP_BITS;
        end else if (inst == MRET_INST) begin
            csr_model[`CSR_MSTATUS_ADDR] = csr_model[`CSR_MSTATUS_ADDR] & ~MPP_BITS;
        end
        return res;
    endfunction

    task automatic check_value(input string name, input data_t got, input data_t want);
        if (got !== want) begin
            errors++;
            $display("FAILED %s: got 0x%h, expected 0x%h, inst 0x%h", name, got, want, i_inst);
        end
    endtask

    // outputs settle well before the rising edge
    always begin : compare
        expect_t want;
        @(negedge clk);
        #(CLK_PERIOD / 4);
        if (checking) begin
            checks++;
            check_value("o_mstatus", o_mstatus, csr_model[`CSR_MSTATUS_ADDR]);
            want = model_step(i_inst, i_rs1_data, i_pc, i_retire);
            check_value("o_rd_data", o_rd_data, want.rd_data);
            check_value("o_illegal", data_t'(o_illegal), data_t'(want.illegal));
            check_value("o_redirect", data_t'(o_redirect), data_t'(want.redirect));
            check_value("o_redirect_pc", o_redirect_pc, want.redirect_pc);
        end
    end

    task automatic drive(input inst_t inst, input data_t rs1, input data_t pc);
        logic [31:0] r;
        r = next_rand();
        @(negedge clk);
        i_inst     = inst;
        i_rs1_data = rs1;
        i_pc       = pc;
        i_retire   = r[7];
    endtask

    task automatic read_csr(input csr_addr_t addr);
        drive(csr_inst(3'b010, addr, 5'd0), next_rand(), next_rand());
    endtask

    // zero source field about a quarter of the time
    task automatic random_access(input csr_addr_t addr);
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  field;
        r     = next_rand();
        f3    = {r[2], ((r[1:0] == 2'b00) ? 2'b01 : r[1:0])};
        field = (r[4:3] == 2'b00) ? 5'd0 : r[9:5];
        drive(csr_inst(f3, addr, field), next_rand(), next_rand());
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        if (errors == test_err_base) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d mismatches", name, errors - test_err_base);
        end
        test_err_base = errors;
    endtask

    initial begin : watchdog
        #((TEST_CYCLES + MARGIN) * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", TEST_CYCLES + MARGIN);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        int          gap;
        csr_addr_t   addr;
        clk           = 1'b0;
        reset         = 1'b1;
        i_inst        = NOP_INST;
        i_pc          = '0;
        i_rs1_data    = '0;
        i_retire      = 1'b0;
        checking      = 1'b0;
        errors        = 0;
        checks        = 0;
        test_err_base = 0;
        tests_passed  = 0;
        tests_failed  = 0;
        rng_state     = 32'h260b_e963;
        model_reset();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset    = 1'b0;
        checking = 1'b1;

        foreach (RW_ADDRS[k]) begin
            read_csr(RW_ADDRS[k]);
        end
        read_csr(`CSR_MVENDORID_ADDR);
        read_csr(`CSR_MARCHID_ADDR);
        finish_test("reset_state");

        for (int i = 0; i < N_RMW; i++) begin
            addr = RW_ADDRS[int'(next_rand() % 32'd9)];
            random_access(addr);
            read_csr(addr);
        end
        finish_test("read_modify_write");

        for (int i = 0; i < N_TRAP; i++) begin
            drive(csr_inst(3'b001, `CSR_MTVEC_ADDR, 5'd1), next_rand(), next_rand());
            drive(ECALL_INST, next_rand(), next_rand());
            read_csr(`CSR_MEPC_ADDR);
            read_csr(`CSR_MCAUSE_ADDR);
            read_csr(`CSR_MSTATUS_ADDR);
            r = next_rand();
            if (r[0]) begin
                drive(csr_inst(3'b001, `CSR_MEPC_ADDR, 5'd1), next_rand(), next_rand());
            end
            drive(MRET_INST, next_rand(), next_rand());
            read_csr(`CSR_MSTATUS_ADDR);
        end
        finish_test("trap_entry_return");

        for (int i = 0; i < N_CNT; i++) begin
            gap = 1 + int'(next_rand() % MAX_GAP);
            read_csr(`CSR_MCYCLE_ADDR);
            repeat (gap) drive(NOP_INST, next_rand(), next_rand());
            read_csr(`CSR_MCYCLE_ADDR);
            gap = 1 + int'(next_rand() % MAX_GAP);
            read_csr(`CSR_MINSTRET_ADDR);
            repeat (gap) drive(NOP_INST, next_rand(), next_rand());
            read_csr(`CSR_MINSTRET_ADDR);
            random_access(`CSR_MCYCLE_ADDR);
            read_csr(`CSR_MCYCLE_ADDR);
            random_access(`CSR_MINSTRET_ADDR);
            read_csr(`CSR_MINSTRET_ADDR);
        end
        finish_test("counters");

        for (int i = 0; i < N_ILL; i++) begin
            r    = next_rand();
            addr = r[0] ? `CSR_MVENDORID_ADDR : `CSR_MARCHID_ADDR;
            drive(csr_inst({r[1], (r[13] ? 2'b10 : 2'b01)}, addr, r[6:2] | 5'd1),
                  next_rand(), next_rand());
            drive(csr_inst(3'b010, r[31:20], r[11:7]), next_rand(), next_rand());
            read_csr(RW_ADDRS[int'(r % 32'd9)]);
        end
        finish_test("illegal_access");

        for (int i = 0; i < N_MIX; i++) begin
            r = next_rand();
            case (r[2:0])
                3'd0, 3'd1, 3'd2: random_access(RW_ADDRS[int'(r[31:8] % 24'd9)]);
                3'd3: random_access(r[20] ? r[31:20] :
                                    (r[21] ? `CSR_MVENDORID_ADDR : `CSR_MARCHID_ADDR));
                3'd4: drive(ECALL_INST, next_rand(), next_rand());
                3'd5: drive(MRET_INST, next_rand(), next_rand());
                3'd6: drive(r[8] ? next_rand() : NOP_INST, next_rand(), next_rand());
                default: read_csr(RW_ADDRS[int'(r[31:8] % 24'd9)]);
            endcase
        end
        finish_test("random_mix");

        checking = 1'b0;
        $display("tests passed: %0d, tests failed: %0d, checks: %0d, mismatches: %0d",
                 tests_passed, tests_failed, checks, errors);
        if (tests_failed == 0 && checks > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/sys_decode.sv
verilog/trap_csrs.sv
verilog/perf_counters.sv
verilog/csr_result.sv
verilog/csr_unit.sv
verification/csr_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = csr_unit_tb
FILELIST  = list.f
BUILD_DIR = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
